/* source/nav_pkg.sv */
package nav_pkg;

	// distance from the ultrasonic ranger
	typedef logic [7:0] distance_t; // whole cm, saturates at 255

	// heading from the camera direction detector
	typedef logic [4:0] direction_t; // 0..24, 12 straight ahead

	typedef struct packed {
		logic       no_target; // no target in view
		direction_t direction; // low bits, averaged by the filter
	} heading_sample_t;

	// ranging constants
	localparam int CYCLES_PER_CM = 4;    // echo cycles per cm
	localparam int RANGE_PERIOD  = 2048; // cycles between trigger starts
	localparam int TRIG_CYCLES   = 10;   // trigger pulse width
	localparam int ECHO_TIMEOUT  = 1100; // no echo by this cycle -> far

	// derived counter widths
	localparam int PERIOD_W = $clog2(RANGE_PERIOD);
	localparam int CM_SUB_W = $clog2(CYCLES_PER_CM);

	localparam distance_t DIST_MAX = 8'd255; // reported on timeout

endpackage

/* source/link_pkg.sv */
package link_pkg;

	// motion commands sent to the base
	typedef enum logic [2:0] {
		STOP,
		FORWARD,
		BACK,
		LEFT,
		RIGHT,
		SEARCH,
		HOLD
	} drive_cmd_e;

	typedef struct packed {
		logic       manual; // from the override, sent in lower case
		drive_cmd_e cmd;
	} cmd_word_t;

	// ascii codes on the serial link
	localparam logic [7:0] ASCII_STOP    = "S";
	localparam logic [7:0] ASCII_FORWARD = "F";
	localparam logic [7:0] ASCII_BACK    = "B";
	localparam logic [7:0] ASCII_LEFT    = "L";
	localparam logic [7:0] ASCII_RIGHT   = "R";
	localparam logic [7:0] ASCII_SEARCH  = "?";
	localparam logic [7:0] ASCII_HOLD    = "H";
	localparam logic [7:0] ASCII_LOWER   = 8'h20; // case bit

	// uart framing, 8N1
	localparam int BAUD_DIV   = 16; // clocks per bit
	localparam int BAUD_W     = $clog2(BAUD_DIV);
	localparam int FRAME_BITS = 10; // start + 8 data + stop
	localparam int FRAME_W    = $clog2(FRAME_BITS);

	// decision thresholds
	localparam int STOP_CM      = 20;
	localparam int FOLLOW_LO_CM = 60;
	localparam int FOLLOW_HI_CM = 100;
	localparam int DIR_CENTER   = 12;
	localparam int DIR_DEADBAND = 3;

endpackage

/* source/echo_ranger.sv */
module echo_ranger import nav_pkg::*; (
	input  logic      clk_50,
	input  logic      reset,
	input  logic      echo,
	output logic      trig,
	output distance_t distance,
	output logic      dist_valid
);

	logic [PERIOD_W-1:0] period_cnt; // cycle index within the period
	logic [CM_SUB_W-1:0] sub_cnt;    // cycles into the current cm
	distance_t           cm_cnt;     // whole cm so far
	logic                echo_d;     // echo one cycle ago
	logic                done;       // result already sent this period
	logic                period_end;
	logic                armed;
	logic                echo_fall;
	logic                report_echo;
	logic                report_timeout;

	assign period_end     = (period_cnt == PERIOD_W'(RANGE_PERIOD - 1));
	assign armed          = !done && !period_end;
	assign echo_fall      = echo_d && !echo;
	assign report_echo    = armed && echo_fall;
	assign report_timeout = armed && !echo_fall && (period_cnt == PERIOD_W'(ECHO_TIMEOUT));

	always_ff @(posedge clk_50 or posedge reset) begin
		if (reset) begin
			period_cnt <= PERIOD_W'(RANGE_PERIOD - 1); // wraps to 0 on first clock
			trig       <= 1'b0;
			echo_d     <= 1'b0;
			done       <= 1'b1; // nothing to report before first trigger
			sub_cnt    <= '0;
			cm_cnt     <= '0;
			dist_valid <= 1'b0;
		end else begin
			echo_d     <= echo;
			period_cnt <= period_end ? '0 : period_cnt + 1'b1;
			trig       <= period_end || (period_cnt < PERIOD_W'(TRIG_CYCLES - 1)); // cycles 0..9
			dist_valid <= report_echo || report_timeout;
			if (period_end) begin // fresh measurement
				done    <= 1'b0;
				sub_cnt <= '0;
				cm_cnt  <= '0;
			end else if (report_echo || report_timeout) begin
				done <= 1'b1;
			end else if (armed && echo) begin
				if (sub_cnt == CM_SUB_W'(CYCLES_PER_CM - 1)) begin // one more whole cm
					sub_cnt <= '0;
					if (cm_cnt != DIST_MAX)
						cm_cnt <= cm_cnt + 1'b1; // saturate
				end else begin
					sub_cnt <= sub_cnt + 1'b1;
				end
			end
		end
	end

	// result register
	always_ff @(posedge clk_50) begin
		if (report_echo)
			distance <= cm_cnt; // floor(width / CYCLES_PER_CM)
		else if (report_timeout)
			distance <= DIST_MAX; // missing or overlong echo
	end

endmodule

/* source/smoothing_filter.sv */
module smoothing_filter #(
	parameter type sample_t   = logic [7:0],
	parameter int  VALUE_BITS = $bits(sample_t) // numeric field in the low bits
) (
	input  logic    clk_50,
	input  logic    reset,
	input  sample_t sample,
	input  logic    sample_valid,
	output sample_t smoothed,
	output logic    smoothed_valid
);

	localparam int SAMPLE_BITS = $bits(sample_t);

	logic [SAMPLE_BITS-1:0] old_bits;  // current output as a vector
	logic [SAMPLE_BITS-1:0] next_bits; // flags from the sample, value averaged
	logic [VALUE_BITS+1:0]  acc;       // 3*old + new, two spare bits

	assign old_bits = smoothed;

	always_comb begin
		acc = {2'b00, old_bits[VALUE_BITS-1:0]}
			+ {1'b0, old_bits[VALUE_BITS-1:0], 1'b0}
			+ {2'b00, sample[VALUE_BITS-1:0]};
		next_bits                   = sample; // upper flag bits pass through
		next_bits[VALUE_BITS-1:0]   = acc[VALUE_BITS+1:2]; // divide by 4, floor
	end

	always_ff @(posedge clk_50 or posedge reset) begin
		if (reset) begin
			smoothed       <= sample_t'('0); // average starts at zero
			smoothed_valid <= 1'b0;
		end else begin
			smoothed_valid <= sample_valid;
			if (sample_valid)
				smoothed <= sample_t'(next_bits);
		end
	end

endmodule

/* source/drive_decider.sv */
module drive_decider import nav_pkg::*, link_pkg::*; (
	input  logic            clk_50,
	input  logic            reset,
	input  distance_t       distance,
	input  logic            dist_valid,
	input  heading_sample_t heading,
	input  logic            manual_active,
	input  drive_cmd_e      manual_cmd,
	output cmd_word_t       cmd,
	output logic            cmd_req,
	input  logic            cmd_ack
);

	cmd_word_t decision;   // combinational choice
	cmd_word_t last_word;  // newest changed word, also the one still to send
	logic      have_last;  // something sent since reset
	logic      pend_valid;
	logic      changed;    // new word on this strobe
	logic      idle;       // four-phase cycle fully closed

	// priority rules with the top one winning
	always_comb begin
		decision.manual = 1'b0;
		decision.cmd    = HOLD;
		if (manual_active) begin
			decision.manual = 1'b1;
			decision.cmd    = manual_cmd;
		end else if (heading.no_target)
			decision.cmd = SEARCH;
		else if (distance < STOP_CM)
			decision.cmd = STOP;
		else if (heading.direction < DIR_CENTER - DIR_DEADBAND)
			decision.cmd = LEFT;
		else if (heading.direction > DIR_CENTER + DIR_DEADBAND)
			decision.cmd = RIGHT;
		else if (distance < FOLLOW_LO_CM)
			decision.cmd = BACK; // too close to target
		else if (distance > FOLLOW_HI_CM)
			decision.cmd = FORWARD; // falling behind
	end

	assign changed = dist_valid && (!have_last || (decision != last_word));
	assign idle    = !cmd_req && !cmd_ack;

	always_ff @(posedge clk_50 or posedge reset) begin
		if (reset) begin
			cmd_req    <= 1'b0;
			pend_valid <= 1'b0;
			have_last  <= 1'b0;
		end else begin
			if (changed)
				have_last <= 1'b1;
			if (cmd_req && cmd_ack)
				cmd_req <= 1'b0; // phase 3
			if (idle && (changed || pend_valid)) begin
				cmd_req    <= 1'b1; // phase 1
				pend_valid <= 1'b0;
			end else if (changed) begin
				pend_valid <= 1'b1; // newest word overwrites
			end
		end
	end

	// words
	always_ff @(posedge clk_50) begin
		if (changed)
			last_word <= decision;
		if (idle && changed)
			cmd <= decision; // straight through when free
		else if (idle && pend_valid)
			cmd <= last_word;
	end

endmodule

/* source/command_link.sv */
module command_link import link_pkg::*; (
	input  logic       clk_50,
	input  logic       reset,
	input  cmd_word_t  cmd,
	input  logic       cmd_req,
	output logic       cmd_ack,
	output logic [7:0] tx_byte,
	output logic       tx_req,
	input  logic       tx_ack
);

	typedef enum logic [1:0] {
		L_IDLE, // waiting for a command
		L_LOAD, // byte latched, req next cycle
		L_REQ,  // waiting for uart ack
		L_DONE  // waiting for uart ack to drop
	} link_state_e;

	link_state_e state;
	logic [7:0]  code; // upper case code of cmd
	logic        take; // accept a command this cycle

	always_comb begin
		case (cmd.cmd)
			STOP:    code = ASCII_STOP;
			FORWARD: code = ASCII_FORWARD;
			BACK:    code = ASCII_BACK;
			LEFT:    code = ASCII_LEFT;
			RIGHT:   code = ASCII_RIGHT;
			SEARCH:  code = ASCII_SEARCH;
			default: code = ASCII_HOLD;
		endcase
	end

	assign take = (state == L_IDLE) && cmd_req && !cmd_ack;

	always_ff @(posedge clk_50 or posedge reset) begin
		if (reset) begin
			state   <= L_IDLE;
			cmd_ack <= 1'b0;
			tx_req  <= 1'b0;
		end else begin
			if (cmd_ack && !cmd_req)
				cmd_ack <= 1'b0; // phase 4, command side
			case (state)
				L_IDLE: if (take) begin
					cmd_ack <= 1'b1; // phase 2, command side
					state   <= L_LOAD;
				end
				L_LOAD: begin
					tx_req <= 1'b1;
					state  <= L_REQ;
				end
				L_REQ: if (tx_ack) begin
					tx_req <= 1'b0;
					state  <= L_DONE;
				end
				default: if (!tx_ack)
					state <= L_IDLE; // uart cycle closed
			endcase
		end
	end

	always_ff @(posedge clk_50) begin
		if (take)
			tx_byte <= cmd.manual ? (code | ASCII_LOWER) : code; // lower case if manual
	end

endmodule

/* source/uart_tx.sv */
module uart_tx import link_pkg::*; (
	input  logic       clk_50,
	input  logic       reset,
	input  logic [7:0] tx_byte,
	input  logic       tx_req,
	output logic       tx_ack,
	output logic       txd
);

	logic [FRAME_BITS-1:0] shift_reg; // bit 0 on the line
	logic [BAUD_W-1:0]     baud_cnt;
	logic [FRAME_W-1:0]    bit_cnt;  // bits sent in this frame
	logic                  busy;
	logic                  load;
	logic                  bit_end;

	assign load    = !busy && tx_req && !tx_ack;
	assign bit_end = (baud_cnt == BAUD_W'(BAUD_DIV - 1));
	assign txd     = shift_reg[0];

	always_ff @(posedge clk_50 or posedge reset) begin
		if (reset) begin
			shift_reg <= '1; // line idles high
			baud_cnt  <= '0;
			bit_cnt   <= '0;
			busy      <= 1'b0;
			tx_ack    <= 1'b0;
		end else begin
			if (tx_ack && !tx_req)
				tx_ack <= 1'b0; // phase 4
			if (load) begin
				shift_reg <= {1'b1, tx_byte, 1'b0}; // stop, data lsb first, start
				baud_cnt  <= '0;
				bit_cnt   <= '0;
				busy      <= 1'b1;
				tx_ack    <= 1'b1; // phase 2, ack on load
			end else if (busy) begin
				if (bit_end) begin
					baud_cnt  <= '0;
					shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]}; // refill with idle
					if (bit_cnt == FRAME_W'(FRAME_BITS - 1))
						busy <= 1'b0; // stop bit done
					else
						bit_cnt <= bit_cnt + 1'b1;
				end else begin
					baud_cnt <= baud_cnt + 1'b1;
				end
			end
		end
	end

endmodule

/* source/robot_nav_top.sv */
module robot_nav_top import nav_pkg::*, link_pkg::*; (
	input  logic            clk_50,
	input  logic            reset,
	input  logic            echo,
	output logic            trig,
	input  heading_sample_t head_sample,
	input  logic            head_valid,
	input  logic            manual_active,
	input  drive_cmd_e      manual_cmd,
	output logic            txd
);

	distance_t       raw_dist;   // ranger to filter
	logic            raw_valid;
	distance_t       filt_dist;  // filter to decider
	logic            filt_valid;
	heading_sample_t filt_head;  // latest smoothed heading
	cmd_word_t       cmd;        // decider to link
	logic            cmd_req;
	logic            cmd_ack;
	logic [7:0]      tx_byte;    // link to uart
	logic            tx_req;
	logic            tx_ack;

	echo_ranger ranger_i (
		.clk_50     (clk_50),
		.reset      (reset),
		.echo       (echo),       // from sensor
		.trig       (trig),       // to sensor
		.distance   (raw_dist),
		.dist_valid (raw_valid)
	);

	smoothing_filter #(.sample_t(distance_t)) dist_filter_i (
		.clk_50         (clk_50),
		.reset          (reset),
		.sample         (raw_dist),
		.sample_valid   (raw_valid),
		.smoothed       (filt_dist),
		.smoothed_valid (filt_valid)
	);

	smoothing_filter #(
		.sample_t   (heading_sample_t),
		.VALUE_BITS ($bits(direction_t)) // no_target rides on top
	) head_filter_i (
		.clk_50         (clk_50),
		.reset          (reset),
		.sample         (head_sample),
		.sample_valid   (head_valid),
		.smoothed       (filt_head),
		.smoothed_valid ()            // decider reads level only
	);

	drive_decider decider_i (
		.clk_50        (clk_50),
		.reset         (reset),
		.distance      (filt_dist),
		.dist_valid    (filt_valid),
		.heading       (filt_head),
		.manual_active (manual_active),
		.manual_cmd    (manual_cmd),
		.cmd           (cmd),
		.cmd_req       (cmd_req),
		.cmd_ack       (cmd_ack)
	);

	command_link link_i (
		.clk_50  (clk_50),
		.reset   (reset),
		.cmd     (cmd),
		.cmd_req (cmd_req),
		.cmd_ack (cmd_ack),
		.tx_byte (tx_byte),
		.tx_req  (tx_req),
		.tx_ack  (tx_ack)
	);

	uart_tx uart_i (
		.clk_50  (clk_50),
		.reset   (reset),
		.tx_byte (tx_byte),
		.tx_req  (tx_req),
		.tx_ack  (tx_ack),
		.txd     (txd)     // to base
	);

endmodule

/* tests/nav_checker.sv */
module nav_checker import nav_pkg::*, link_pkg::*; (
	input  logic       clk_50,
	input  logic       reset,
	input  logic       txd,
	input  logic       trig,
	input  logic       dist_valid,
	input  distance_t  distance,
	input  distance_t  exp_dist,
	input  logic       exp_push,
	input  logic [7:0] exp_char,
	input  logic       test_done,
	input  int         test_num,
	output int         errors,
	output int         bytes_rx
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MID_START = BAUD_DIV / 2 - 1; // cycles from start detect to mid start bit

	logic [7:0] exp_q[$];    // characters from the reference model
	logic [7:0] rx_data;     // shifted in lsb first
	logic [7:0] want;
	logic       rx_busy;
	logic       saw_dist;    // first measurement done
	logic       idle_checked;
	logic       trig_d;      // trig on the previous clock
	logic       seen_rise;   // one trigger start seen
	int         trig_high;   // cycles trig has been high
	int         since_rise;  // cycles since the last trigger start
	int         rx_cnt;
	int         slot;        // 0 start, 1..8 data, 9 stop
	int         test_bytes;
	int         test_pushes;
	int         test_errs;   // error count when the test began

	always @(posedge clk_50) begin
		if (reset) begin
			exp_q.delete();
			errors       = 0;
			bytes_rx     = 0;
			rx_busy      = 1'b0;
			saw_dist     = 1'b0;
			idle_checked = 1'b0;
			trig_d       = 1'b0;
			seen_rise    = 1'b0;
			trig_high    = 0;
			since_rise   = 0;
			rx_cnt       = 0;
			rx_data      = '0;
			test_bytes   = 0;
			test_pushes  = 0;
			test_errs    = 0;
		end else begin
			if (!idle_checked) begin // line state right after reset
				idle_checked = 1'b1;
				if (txd !== 1'b1) begin
					$display("FAILED txd after reset: got %h expected %h", txd, 1'b1);
					errors++;
				end
			end
			if (trig && !trig_d) begin // start of a range period
				if (seen_rise && since_rise != RANGE_PERIOD) begin
					$display("FAILED trig period: got %h expected %h",
						since_rise, RANGE_PERIOD);
					errors++;
				end
				seen_rise  = 1'b1;
				since_rise = 0;
				trig_high  = 0;
			end
			if (!trig && trig_d && trig_high != TRIG_CYCLES) begin
				$display("FAILED trig width: got %h expected %h", trig_high, TRIG_CYCLES);
				errors++;
			end
			if (trig)
				trig_high++;
			since_rise++;
			trig_d = trig;
			if (dist_valid) begin // raw ranger result
				saw_dist = 1'b1;
				if (distance !== exp_dist) begin
					$display("FAILED distance: got %h expected %h", distance, exp_dist);
					errors++;
				end
			end
			if (exp_push) begin
				exp_q.push_back(exp_char);
				test_pushes++;
			end
			if (!rx_busy) begin
				if (txd == 1'b0) begin // falling edge of a start bit
					rx_busy = 1'b1;
					rx_cnt  = 0;
					if (!saw_dist) begin
						$display("serial byte started before the first distance measurement");
						errors++;
					end
				end
			end else begin
				rx_cnt++;
				if (rx_cnt >= MID_START && (rx_cnt - MID_START) % BAUD_DIV == 0) begin
					slot = (rx_cnt - MID_START) / BAUD_DIV;
					if (slot == 0) begin
						if (txd !== 1'b0) begin
							$display("FAILED txd start bit: got %h expected %h", txd, 1'b0);
							errors++;
						end
					end else if (slot <= 8) begin
						rx_data = {txd, rx_data[7:1]}; // lsb arrives first
					end else begin
						if (txd !== 1'b1) begin
							$display("FAILED txd stop bit: got %h expected %h", txd, 1'b1);
							errors++;
						end
						rx_busy = 1'b0;
						bytes_rx++;
						test_bytes++;
						if (exp_q.size() == 0) begin
							$display("byte %h arrived with no command change expected", rx_data);
							errors++;
						end else begin
							want = exp_q.pop_front();
							if (rx_data !== want) begin
								$display("FAILED txd byte: got %h expected %h", rx_data, want);
								errors++;
							end
						end
					end
				end
			end
			if (test_done) begin // all bytes should be in by the end of a test
				if (exp_q.size() != 0) begin
					$display("test %0d: %0d expected bytes never arrived", test_num, exp_q.size());
					errors++;
					exp_q.delete();
				end else if (test_bytes != test_pushes) begin
					$display("test %0d: %0d bytes received for %0d command changes",
						test_num, test_bytes, test_pushes);
					errors++;
				end
				$display("test %0d finished %s: %0d bytes, %0d command changes, %0d new errors",
					test_num, (errors == test_errs) ? "clean" : "with errors",
					test_bytes, test_pushes, errors - test_errs);
				test_errs   = errors;
				test_bytes  = 0;
				test_pushes = 0;
			end
		end
	end

endmodule

/* tests/tb_robot_nav.sv */
module tb_robot_nav
	import nav_pkg::*, link_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_TESTS     = 5;
	localparam int PERIODS     = 16;                     // range periods per test
	localparam int CLK_NS      = 40;
	localparam int ECHO_START  = 20;                     // echo rises this many cycles into a period
	localparam int TAIL        = 2 * BAUD_DIV * FRAME_BITS; // last byte drains
	localparam int WATCHDOG_NS = (N_TESTS * PERIODS + 8) * RANGE_PERIOD * CLK_NS;

	logic            clk_50;
	logic            reset;
	logic            echo;
	logic            trig;
	logic            txd;
	heading_sample_t head_sample;
	logic            head_valid;
	logic            manual_active;
	drive_cmd_e      manual_cmd;
	distance_t       exp_dist;
	logic [7:0]      exp_char;
	logic            exp_push;
	logic            test_done;
	int              test_num;
	int              errors;
	int              bytes_rx;
	logic [31:0]     lfsr;

	// per period stimulus
	int   base;       // target distance in cm
	int   w;          // echo width in cycles or 0 when missing
	int   dir_target;
	logic nt_target;

	// reference model state
	int         m_dist;   // smoothed distance
	int         m_dir;    // smoothed heading
	logic       m_nt;
	logic       m_have;   // a word was sent since reset
	drive_cmd_e m_last_cmd;
	logic       m_last_man;

	robot_nav_top dut_i (
		.clk_50        (clk_50),
		.reset         (reset),
		.echo          (echo),
		.trig          (trig),
		.head_sample   (head_sample),
		.head_valid    (head_valid),
		.manual_active (manual_active),
		.manual_cmd    (manual_cmd),
		.txd           (txd)
	);

	nav_checker check_i (
		.clk_50     (clk_50),
		.reset      (reset),
		.txd        (txd),
		.trig       (trig),
		.dist_valid (dut_i.raw_valid), // ranger output before smoothing
		.distance   (dut_i.raw_dist),
		.exp_dist   (exp_dist),
		.exp_push   (exp_push),
		.exp_char   (exp_char),
		.test_done  (test_done),
		.test_num   (test_num),
		.errors     (errors),
		.bytes_rx   (bytes_rx)
	);

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b    = lfsr[0];
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ 32'h80200003;
			r = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic int floor_cm(input int width);
		if (width == 0)
			return 255; // missing echo times out
		if (width / CYCLES_PER_CM > 255)
			return 255;
		return width / CYCLES_PER_CM;
	endfunction

	function automatic drive_cmd_e decide_cmd(input logic nt, input int d, input int dir);
		if (nt)
			return SEARCH;
		if (d < STOP_CM)
			return STOP;
		if (dir < DIR_CENTER - DIR_DEADBAND)
			return LEFT;
		if (dir > DIR_CENTER + DIR_DEADBAND)
			return RIGHT;
		if (d < FOLLOW_LO_CM)
			return BACK;
		if (d > FOLLOW_HI_CM)
			return FORWARD;
		return HOLD;
	endfunction

	function automatic logic [7:0] ascii_of(input drive_cmd_e c, input logic man);
		logic [7:0] a;
		case (c)
			STOP:    a = "S";
			FORWARD: a = "F";
			BACK:    a = "B";
			LEFT:    a = "L";
			RIGHT:   a = "R";
			SEARCH:  a = "?";
			default: a = "H";
		endcase
		return man ? (a | 8'h20) : a; // lower case under override
	endfunction

	task automatic pick_period(input int t, input int p);
		manual_active = 1'b0;
		nt_target     = 1'b0;
		dir_target    = 12 + rand_bits(2);
		case (t)
			1: begin // distance sweep
				if (p % 3 == 0)
					base = rand_bits(8);
				w = base * CYCLES_PER_CM + rand_bits(3);
			end
			2: begin // missing echoes
				if (p % 2 == 0)
					base = rand_bits(7);
				w = (rand_bits(2) == 0) ? 0 : base * CYCLES_PER_CM + rand_bits(2);
			end
			3: begin // heading and no target
				base       = rand_bits(8);
				w          = base * CYCLES_PER_CM + rand_bits(2);
				dir_target = rand_bits(5) % 25;
				nt_target  = (rand_bits(2) == 0);
			end
			4: begin // override over everything until near the end
				base          = rand_bits(8);
				w             = base * CYCLES_PER_CM + rand_bits(2);
				dir_target    = rand_bits(5) % 25;
				nt_target     = (rand_bits(2) == 0);
				manual_active = (p < PERIODS - 4) && rand_bits(1);
				manual_cmd    = drive_cmd_e'(3'(rand_bits(3) % 7));
			end
			default: begin // steady scene in the hold zone
				base = 80;
				w    = base * CYCLES_PER_CM + rand_bits(2);
			end
		endcase
	endtask

	task automatic model_step();
		drive_cmd_e c;
		m_dist = (3 * m_dist + floor_cm(w)) / 4;
		c      = manual_active ? manual_cmd : decide_cmd(m_nt, m_dist, m_dir);
		if (!m_have || c != m_last_cmd || manual_active != m_last_man) begin
			exp_char = ascii_of(c, manual_active);
			exp_push = 1'b1; // one character per changed word
		end
		m_have     = 1'b1;
		m_last_cmd = c;
		m_last_man = manual_active;
	endtask

	// one range period driven on falling edges
	task automatic run_period(input int t, input int p);
		int event_k;
		event_k = 0;
		@(posedge trig);
		for (int k = 0; k <= ECHO_TIMEOUT + 2; k++) begin
			@(negedge clk_50);
			exp_push = 1'b0;
			if (k == 0) begin
				pick_period(t, p);
				exp_dist = 8'(floor_cm(w));
				event_k  = (w == 0) ? ECHO_TIMEOUT + 1 : ECHO_START + w;
			end
			head_valid = (k < 8) && (k % 2 == 0); // only while trig is high
			if (head_valid) begin
				head_sample.direction = 5'(dir_target);
				head_sample.no_target = nt_target;
				m_dir = (3 * m_dir + dir_target) / 4;
				m_nt  = nt_target;
			end
			echo = (w != 0) && (k >= ECHO_START) && (k < ECHO_START + w);
			if (k == event_k)
				model_step();
		end
	endtask

	initial begin
		clk_50 = 1'b0;
		forever #(CLK_NS / 2) clk_50 = ~clk_50;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		reset         = 1'b1;
		echo          = 1'b0;
		head_sample   = '0;
		head_valid    = 1'b0;
		manual_active = 1'b0;
		manual_cmd    = STOP;
		exp_dist      = '0;
		exp_char      = '0;
		exp_push      = 1'b0;
		test_done     = 1'b0;
		test_num      = 0;
		lfsr          = 32'h41773ab5;
		base          = 0;
		w             = 0;
		dir_target    = DIR_CENTER;
		nt_target     = 1'b0;
		m_dist        = 0; // filters start at zero
		m_dir         = 0;
		m_nt          = 1'b0;
		m_have        = 1'b0;
		m_last_cmd    = HOLD;
		m_last_man    = 1'b0;
		repeat (16) @(negedge clk_50);
		reset = 1'b0;
		for (int t = 1; t <= N_TESTS; t++) begin
			for (int p = 0; p < PERIODS; p++)
				run_period(t, p);
			repeat (TAIL) @(negedge clk_50);
			test_num  = t;
			test_done = 1'b1;
			@(negedge clk_50);
			test_done = 1'b0;
		end
		@(negedge clk_50);
		$display("tests %0d, bytes %0d, errors %0d", N_TESTS, bytes_rx, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* tb.f */
source/nav_pkg.sv
source/link_pkg.sv
source/echo_ranger.sv
source/smoothing_filter.sv
source/drive_decider.sv
source/command_link.sv
source/uart_tx.sv
source/robot_nav_top.sv
tests/nav_checker.sv
tests/tb_robot_nav.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the robot navigation testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary -Wno-fatal --top-module tb_robot_nav -f tb.f -o tb_robot_nav \
	&& ./obj_dir/tb_robot_nav > "$LOG" 2>&1 \
	|| { cat "$LOG" 2>/dev/null; echo "build or simulation error"; exit 1; }

cat "$LOG"
grep -qF -- '** FAIL **' "$LOG" && { echo "simulation reported a failure"; exit 1; }
echo "simulation finished without failure"
exit 0
